// ==== rtl/core_pkg.sv ====
`default_nettype none

package core_pkg;

	//----------------------------------------
	// basic words
	//----------------------------------------

	// one data or instruction word
	typedef logic [31:0] word_t;

	// register index, x0..x31
	typedef logic [4:0] reg_addr_t;

	// the only two opcodes that execute
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

	// alu operation, coded as {funct7[5], funct3}
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_SLL  = 4'b0001,
		ALU_SLT  = 4'b0010,
		ALU_SLTU = 4'b0011,
		ALU_XOR  = 4'b0100,
		ALU_SRL  = 4'b0101,
		ALU_OR   = 4'b0110,
		ALU_AND  = 4'b0111,
		ALU_SUB  = 4'b1000,
		ALU_SRA  = 4'b1101
	} alu_op_e;

	//----------------------------------------
	// instruction formats
	//----------------------------------------

	// register-register form
	typedef struct packed {
		logic [6:0] funct7;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		reg_addr_t  rd;
		logic [6:0] opcode;
	} r_type_t;

	// register-immediate form
	typedef struct packed {
		logic [11:0] imm12;
		reg_addr_t   rs1;
		logic [2:0]  funct3;
		reg_addr_t   rd;
		logic [6:0]  opcode;
	} i_type_t;

	// same word, seen either way
	typedef union packed {
		r_type_t r;
		i_type_t i;
	} instr_u;

	//----------------------------------------
	// pipeline records
	//----------------------------------------

	// decode register contents
	typedef struct packed {
		logic      valid;
		alu_op_e   alu_op;
		reg_addr_t rd;
		word_t     op_a;
		word_t     op_b;
	} dec_t;

	// result not yet in the register file
	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		word_t     data;
	} fwd_t;

	// write-back port record
	typedef struct packed {
		reg_addr_t rd;
		word_t     data;
	} wb_t;

endpackage

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file import core_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  reg_addr_t rs1,
	input  reg_addr_t rs2,
	output word_t     rdata1,
	output word_t     rdata2,
	input  fwd_t      wr
);

	// x1..x31 only, x0 has no storage
	word_t regs [1:31];

	// single write port, x0 writes dropped
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.valid && (wr.rd != '0)) begin
			regs[wr.rd] <= wr.data;
		end
	end

	// two combinational reads
	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage import core_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	input  word_t instr,
	input  logic  instr_valid,
	output logic  instr_ready,
	input  logic  advance,
	input  fwd_t  alu_fwd,
	input  fwd_t  ex_fwd,
	input  fwd_t  wr,
	output dec_t  dec
);

	// pick the newest value of a source register
	// alu result first, then execute register, then register file
	function automatic word_t fwd_pick(
		input reg_addr_t idx,
		input word_t     rf_data,
		input fwd_t      near,
		input fwd_t      far
	);
		word_t val;
		val = rf_data;
		if (idx == '0) begin
			val = '0;
		end else if (near.valid && (near.rd == idx)) begin
			val = near.data;
		end else if (far.valid && (far.rd == idx)) begin
			val = far.data;
		end
		return val;
	endfunction

	instr_u    iw;
	logic      is_op;
	logic      is_imm;
	logic      is_shift_imm;
	alu_op_e   alu_op;
	word_t     rdata1;
	word_t     rdata2;
	word_t     imm_sext;
	word_t     op_a;
	word_t     op_b;

	//----------------------------------------
	// field extraction
	//----------------------------------------

	assign iw = instr_u'(instr);

	// opcode field sits in the same bits in both forms
	assign is_op        = (iw.r.opcode == OPC_OP);
	assign is_imm       = (iw.i.opcode == OPC_OP_IMM);
	assign is_shift_imm = is_imm && (iw.i.funct3[1:0] == 2'b01);

	// 12-bit immediate, sign extended
	assign imm_sext = {{20{iw.i.imm12[11]}}, iw.i.imm12};

	always_comb begin
		case (iw.r.funct3)
			// sub only in register form
			3'b000: alu_op = (is_op && iw.r.funct7[5]) ? ALU_SUB : ALU_ADD;
			3'b001: alu_op = ALU_SLL;
			3'b010: alu_op = ALU_SLT;
			3'b011: alu_op = ALU_SLTU;
			3'b100: alu_op = ALU_XOR;
			// srl/sra split by funct7[5], same bit as imm12[10]
			3'b101: alu_op = iw.r.funct7[5] ? ALU_SRA : ALU_SRL;
			3'b110: alu_op = ALU_OR;
			default: alu_op = ALU_AND;
		endcase
	end

	//----------------------------------------
	// operand read and forwarding
	//----------------------------------------

	reg_file i_reg_file (
		.clk    (clk),
		.arst_n (arst_n),
		.rs1    (iw.r.rs1),
		.rs2    (iw.r.rs2),
		.rdata1 (rdata1),
		.rdata2 (rdata2),
		.wr     (wr)
	);

	always_comb begin
		op_a = fwd_pick(iw.r.rs1, rdata1, alu_fwd, ex_fwd);
		// shamt lives in the rs2 field
		if (is_shift_imm) begin
			op_b = {27'b0, iw.r.rs2};
		end else if (is_imm) begin
			op_b = imm_sext;
		end else begin
			op_b = fwd_pick(iw.r.rs2, rdata2, alu_fwd, ex_fwd);
		end
	end

	//----------------------------------------
	// decode register
	//----------------------------------------

	// accept whenever the pipe moves
	assign instr_ready = advance;

	// unknown opcodes become bubbles
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dec <= '0;
		end else if (advance) begin
			dec.valid  <= instr_valid && (is_op || is_imm);
			dec.alu_op <= alu_op;
			dec.rd     <= iw.r.rd;
			dec.op_a   <= op_a;
			dec.op_b   <= op_b;
		end
	end

	// an offered word stays put until it is taken
	a_instr_hold: assert property (
		@(posedge clk) disable iff (!arst_n)
		(instr_valid && !instr_ready) |=> (instr_valid && $stable(instr))
	) else $error("decode_stage: instruction changed while waiting");

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage import core_pkg::*; (
	input  logic clk,
	input  logic arst_n,
	input  logic advance,
	input  dec_t dec,
	output fwd_t alu_fwd,
	output fwd_t ex_rec
);

	word_t       alu_res;
	logic [4:0]  shamt;
	logic signed [31:0] op_a_s;
	logic signed [31:0] op_b_s;

	//----------------------------------------
	// arithmetic/logic unit
	//----------------------------------------

	// shifts only look at the low five bits
	assign shamt  = dec.op_b[4:0];
	assign op_a_s = dec.op_a;
	assign op_b_s = dec.op_b;

	always_comb begin
		case (dec.alu_op)
			ALU_ADD:  alu_res = dec.op_a + dec.op_b;
			// wraps modulo 2^32
			ALU_SUB:  alu_res = dec.op_a - dec.op_b;
			ALU_SLL:  alu_res = dec.op_a << shamt;
			// compares give 0 or 1
			ALU_SLT:  alu_res = {31'b0, op_a_s < op_b_s};
			ALU_SLTU: alu_res = {31'b0, dec.op_a < dec.op_b};
			ALU_XOR:  alu_res = dec.op_a ^ dec.op_b;
			ALU_SRL:  alu_res = dec.op_a >> shamt;
			// sign bit fills from the left
			ALU_SRA:  alu_res = op_a_s >>> shamt;
			ALU_OR:   alu_res = dec.op_a | dec.op_b;
			ALU_AND:  alu_res = dec.op_a & dec.op_b;
			default:  alu_res = '0;
		endcase
	end

	// result of the instruction now in execute
	// goes straight back to decode
	assign alu_fwd.valid = dec.valid;
	assign alu_fwd.rd    = dec.rd;
	assign alu_fwd.data  = alu_res;

	//----------------------------------------
	// execute register
	//----------------------------------------

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_rec <= '0;
		end else if (advance) begin
			// bubbles pass through with valid low
			ex_rec <= alu_fwd;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/result_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_stage import core_pkg::*; (
	input  logic clk,
	input  logic arst_n,
	input  fwd_t ex_rec,
	output logic advance,
	output fwd_t wr,
	output fwd_t ex_fwd,
	output wb_t  wb,
	output logic wb_valid,
	input  logic wb_ready
);

	fwd_t res_q;

	// global stall, only when a held result is not taken
	assign advance = !(res_q.valid && !wb_ready);

	// register write on the edge the record enters res_q
	assign wr.valid = ex_rec.valid && advance;
	assign wr.rd    = ex_rec.rd;
	assign wr.data  = ex_rec.data;

	// execute register seen by decode
	assign ex_fwd = ex_rec;

	//----------------------------------------
	// result register
	//----------------------------------------

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			res_q <= '0;
		end else if (advance) begin
			res_q <= ex_rec;
		end
	end

	// write-back port
	assign wb_valid = res_q.valid;
	assign wb.rd    = res_q.rd;
	assign wb.data  = res_q.data;

	// execute register frozen along with the result register
	a_ex_hold: assert property (
		@(posedge clk) disable iff (!arst_n)
		!advance |=> $stable(ex_rec)
	) else $error("result_stage: execute register moved during stall");

endmodule

`default_nettype wire

// ==== rtl/core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_top import core_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	input  word_t instr,
	input  logic  instr_valid,
	output logic  instr_ready,
	output wb_t   wb,
	output logic  wb_valid,
	input  logic  wb_ready
);

	// pipe-wide enable, low stalls every stage
	logic advance;

	// stage records
	dec_t dec;
	fwd_t alu_fwd;
	fwd_t ex_rec;
	fwd_t ex_fwd;
	fwd_t wr;

	//----------------------------------------
	// decode, execute, result
	//----------------------------------------

	decode_stage i_decode_stage (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr       (instr),
		.instr_valid (instr_valid),
		.instr_ready (instr_ready),
		.advance     (advance),
		.alu_fwd     (alu_fwd),
		.ex_fwd      (ex_fwd),
		.wr          (wr),
		.dec         (dec)
	);

	execute_stage i_execute_stage (
		.clk     (clk),
		.arst_n  (arst_n),
		.advance (advance),
		.dec     (dec),
		.alu_fwd (alu_fwd),
		.ex_rec  (ex_rec)
	);

	result_stage i_result_stage (
		.clk      (clk),
		.arst_n   (arst_n),
		.ex_rec   (ex_rec),
		.advance  (advance),
		.wr       (wr),
		.ex_fwd   (ex_fwd),
		.wb       (wb),
		.wb_valid (wb_valid),
		.wb_ready (wb_ready)
	);

endmodule

`default_nettype wire

// ==== include/tb_program.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

	// columns: row name, instruction word, expected rd, expected data
	// add_skip rows have no write-back
	task automatic load_program();
		// first read of untouched registers
		add_row("add_zero", r_op(F7_BASE, F3_ADD, 5'd1, 5'd2, 5'd3), 5'd1, 32'h0000_0000);

		// operand setup, x1 = 0x123, x2 = -5
		add_row("addi_pos", i_op(F3_ADD, 5'd1, 5'd0, 12'h123), 5'd1, 32'h0000_0123);
		add_row("addi_neg", i_op(F3_ADD, 5'd2, 5'd0, 12'hffb), 5'd2, 32'hffff_fffb);

		// register-register ops, back to back on x1/x2
		add_row("add", r_op(F7_BASE, F3_ADD, 5'd3, 5'd1, 5'd2), 5'd3, 32'h0000_011e);
		add_row("sub", r_op(F7_ALT, F3_ADD, 5'd4, 5'd1, 5'd2), 5'd4, 32'h0000_0128);
		add_row("sub_wrap", r_op(F7_ALT, F3_ADD, 5'd5, 5'd0, 5'd1), 5'd5, 32'hffff_fedd);
		// -5 vs 0x123, signed and unsigned disagree
		add_row("slt", r_op(F7_BASE, F3_SLT, 5'd6, 5'd2, 5'd1), 5'd6, 32'h0000_0001);
		add_row("sltu", r_op(F7_BASE, F3_SLTU, 5'd7, 5'd2, 5'd1), 5'd7, 32'h0000_0000);
		add_row("xor", r_op(F7_BASE, F3_XOR, 5'd8, 5'd1, 5'd2), 5'd8, 32'hffff_fed8);
		add_row("or", r_op(F7_BASE, F3_OR, 5'd9, 5'd1, 5'd2), 5'd9, 32'hffff_fffb);
		add_row("and", r_op(F7_BASE, F3_AND, 5'd10, 5'd1, 5'd2), 5'd10, 32'h0000_0123);

		// shifts by register, x11 = 4
		add_row("addi_four", i_op(F3_ADD, 5'd11, 5'd0, 12'h004), 5'd11, 32'h0000_0004);
		add_row("sll", r_op(F7_BASE, F3_SLL, 5'd12, 5'd1, 5'd11), 5'd12, 32'h0000_1230);
		add_row("srl", r_op(F7_BASE, F3_SR, 5'd13, 5'd2, 5'd11), 5'd13, 32'h0fff_ffff);
		add_row("sra", r_op(F7_ALT, F3_SR, 5'd14, 5'd2, 5'd11), 5'd14, 32'hffff_ffff);
		// x5 low five bits are 29
		add_row("sll_low5", r_op(F7_BASE, F3_SLL, 5'd15, 5'd1, 5'd5), 5'd15, 32'h6000_0000);

		// immediate forms
		add_row("slti", i_op(F3_SLT, 5'd16, 5'd2, 12'hffc), 5'd16, 32'h0000_0001);
		add_row("sltiu", i_op(F3_SLTU, 5'd17, 5'd1, 12'hfff), 5'd17, 32'h0000_0001);
		add_row("xori", i_op(F3_XOR, 5'd18, 5'd1, 12'h7ff), 5'd18, 32'h0000_06dc);
		add_row("ori_neg", i_op(F3_OR, 5'd19, 5'd0, 12'h800), 5'd19, 32'hffff_f800);
		add_row("andi", i_op(F3_AND, 5'd20, 5'd2, 12'h0f0), 5'd20, 32'h0000_00f0);
		add_row("slli", i_op(F3_SLL, 5'd21, 5'd1, 12'h008), 5'd21, 32'h0001_2300);
		add_row("srli", i_op(F3_SR, 5'd22, 5'd19, 12'h00b), 5'd22, 32'h001f_ffff);
		add_row("srai", i_op(F3_SR, 5'd23, 5'd19, 12'h40b), 5'd23, 32'hffff_ffff);
		add_row("srai_pos", i_op(F3_SR, 5'd24, 5'd1, 12'h404), 5'd24, 32'h0000_0012);

		// dependent chain through x25..x27
		add_row("chain_a", i_op(F3_ADD, 5'd25, 5'd0, 12'h001), 5'd25, 32'h0000_0001);
		add_row("chain_b", r_op(F7_BASE, F3_ADD, 5'd25, 5'd25, 5'd25), 5'd25, 32'h0000_0002);
		add_row("chain_c", r_op(F7_BASE, F3_ADD, 5'd25, 5'd25, 5'd25), 5'd25, 32'h0000_0004);
		add_row("chain_d", i_op(F3_ADD, 5'd26, 5'd25, 12'h00a), 5'd26, 32'h0000_000e);
		add_row("chain_e", r_op(F7_ALT, F3_ADD, 5'd27, 5'd26, 5'd25), 5'd27, 32'h0000_000a);
		// lui x1, bubble in decode
		add_skip("skip_lui", 32'h0010_00b7);
		// x27 from execute register, x26 from register file
		add_row("three_path", r_op(F7_BASE, F3_ADD, 5'd28, 5'd27, 5'd26), 5'd28, 32'h0000_0018);

		// x0 written, still reads zero
		add_row("x0_write", i_op(F3_ADD, 5'd0, 5'd1, 12'h055), 5'd0, 32'h0000_0178);
		add_row("x0_alu", r_op(F7_BASE, F3_ADD, 5'd29, 5'd0, 5'd0), 5'd29, 32'h0000_0000);
		add_row("x0_exreg", r_op(F7_BASE, F3_ADD, 5'd30, 5'd0, 5'd1), 5'd30, 32'h0000_0123);
		// addw-style opcode, not rv32i
		add_skip("skip_opw", 32'h0021_81bb);
		add_row("x0_regfile", r_op(F7_BASE, F3_ADD, 5'd31, 5'd1, 5'd0), 5'd31, 32'h0000_0123);
	endtask

`endif

// ==== verification/tb_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_core import core_pkg::*; ();

	//----------------------------------------
	// table types and encoders
	//----------------------------------------

	// one program row and its expected write-back
	typedef struct packed {
		word_t     word;
		logic      writes;
		reg_addr_t rd;
		word_t     data;
	} prog_entry_t;

	localparam int CYCLES_PER_ROW = 20;
	localparam int TIMEOUT_MARGIN = 100;
	localparam int QUIET_CYCLES   = 10;

	// funct3 codes
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;
	// funct7, alt selects sub/sra
	localparam logic [6:0] F7_BASE = 7'h00;
	localparam logic [6:0] F7_ALT  = 7'h20;

	logic        clk;
	logic        arst_n;
	word_t       instr;
	logic        instr_valid;
	logic        instr_ready;
	wb_t         wb;
	logic        wb_valid;
	logic        wb_ready;
	prog_entry_t prog [$];
	string       prog_name [$];
	int          cycles;

	// register-register word
	function automatic word_t r_op(input logic [6:0] funct7, input logic [2:0] funct3,
			input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2);
		return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
	endfunction

	// register-immediate word
	function automatic word_t i_op(input logic [2:0] funct3, input reg_addr_t rd,
			input reg_addr_t rs1, input logic [11:0] imm);
		return {imm, rs1, funct3, rd, 7'b0010011};
	endfunction

	task automatic add_row(input string name, input word_t word, input reg_addr_t rd,
			input word_t data);
		prog.push_back('{word, 1'b1, rd, data});
		prog_name.push_back(name);
	endtask

	// word that must leave no write-back
	task automatic add_skip(input string name, input word_t word);
		prog.push_back('{word, 1'b0, 5'd0, 32'h0});
		prog_name.push_back(name);
	endtask

	`include "tb_program.svh"

	// next row from idx on that writes back
	function automatic int next_writer(input int idx);
		int i;
		i = idx;
		while ((i < prog.size()) && !prog[i].writes) begin
			i++;
		end
		return i;
	endfunction

	//----------------------------------------
	// DUT, clock, timeout
	//----------------------------------------

	core_top i_dut (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr       (instr),
		.instr_valid (instr_valid),
		.instr_ready (instr_ready),
		.wb          (wb),
		.wb_valid    (wb_valid),
		.wb_ready    (wb_ready)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// limit grows with the table
	initial begin
		cycles = 0;
		while (cycles <= CYCLES_PER_ROW * prog.size() + TIMEOUT_MARGIN) begin
			@(posedge clk);
			cycles++;
		end
		$display("*** TEST FAILED ***");
		$fatal(1, "timeout: the run did not finish within %0d cycles", cycles);
	end

	//----------------------------------------
	// stimulus and checking
	//----------------------------------------

	// random back-pressure, ready three times in four
	task automatic drive_ready();
		forever begin
			@(negedge clk);
			wb_ready = ($urandom % 4) != 0;
		end
	endtask

	task automatic feed_program();
		for (int i = 0; i < prog.size(); i++) begin
			instr       = prog[i].word;
			instr_valid = 1'b1;
			// hold the word until the edge that takes it
			do begin
				@(posedge clk);
			end while (!instr_ready);
			@(negedge clk);
		end
		instr_valid = 1'b0;
		instr       = '0;
	endtask

	task automatic check_writebacks();
		int idx;
		idx = next_writer(0);
		while (idx < prog.size()) begin
			@(posedge clk);
			if (wb_valid && wb_ready) begin
				assert (wb.rd == prog[idx].rd) else begin
					$display("** Error %s: rd expected %0d, actual %0d",
						prog_name[idx], prog[idx].rd, wb.rd);
					$display("*** TEST FAILED ***");
					$fatal(1, "write-back register mismatch");
				end
				assert (wb.data == prog[idx].data) else begin
					$display("** Error %s: data expected %h, actual %h",
						prog_name[idx], prog[idx].data, wb.data);
					$display("*** TEST FAILED ***");
					$fatal(1, "write-back data mismatch");
				end
				idx = next_writer(idx + 1);
			end
		end
		// no extra records after the last one
		repeat (QUIET_CYCLES) begin
			@(posedge clk);
			assert (!wb_valid) else begin
				$display("write-back offered after the last expected one, rd %0d data %h",
					wb.rd, wb.data);
				$display("*** TEST FAILED ***");
				$fatal(1, "extra write-back");
			end
		end
	endtask

	initial begin
		arst_n      = 1'b0;
		instr       = '0;
		instr_valid = 1'b0;
		wb_ready    = 1'b0;
		void'($urandom(32'h1f2c));
		load_program();

		// four cycles in reset
		repeat (4) @(negedge clk);
		arst_n = 1'b1;

		assert (!wb_valid) else begin
			$display("** Error reset: wb_valid expected 0, actual %0b", wb_valid);
			$display("*** TEST FAILED ***");
			$fatal(1, "wb_valid high after reset");
		end
		assert (instr_ready) else begin
			$display("** Error reset: instr_ready expected 1, actual %0b", instr_ready);
			$display("*** TEST FAILED ***");
			$fatal(1, "instr_ready low after reset");
		end

		fork
			drive_ready();
		join_none
		fork
			feed_program();
			check_writebacks();
		join

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+include
rtl/core_pkg.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/result_stage.sv
rtl/core_top.sv
verification/tb_core.sv

// ==== Makefile ====
# Verilator build and run of the pipeline testbench

VERILATOR ?= verilator
TOP       := tb_core
FILELIST  := compile.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# the run returns nonzero when the testbench stops on $$fatal
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
